// ==== Bender.yml ====
package:
  name: ncpu32k_icache

dependencies: {}

sources:
  # shared package first
  - common/ncpu32k_icache_pkg.sv
  # RTL
  - hdl/ncpu32k_cell_sdpram_sclk.sv
  - icache/ncpu32k_icache_ctrl.sv
  - icache/ncpu32k_icache.sv
  # testbench
  - target: test
    files:
      - dv/ncpu32k_icache_mem_model.sv
      - dv/ncpu32k_icache_tb.sv

// ==== common/ncpu32k_icache_pkg.sv ====
/*
 * ncpu32k icache shared definitions
 * cache geometry, RAM widths and the fetch address view
 */

package ncpu32k_icache_pkg;

   // #################### geometry
   localparam int addr_w     = 32;     // fetch address
   localparam int data_w     = 32;     // one instruction word
   localparam int offs_w     = 4;      // 16-byte lines
   localparam int word_w     = 2;      // word select in a line
   localparam int index_w    = 6;
   localparam int tag_w      = addr_w - index_w - offs_w;   // 22
   localparam int line_words = 1 << word_w;                 // 4
   localparam int num_lines  = 1 << index_w;                // 64

   // #################### RAM widths
   localparam int data_ram_aw = index_w + word_w;   // {index, word}
   localparam int tag_ram_dw  = tag_w + 1;          // msb is the valid flag

   // fetch address split into its cache fields
   typedef struct packed {
      logic [tag_w-1:0]          tag;
      logic [index_w-1:0]        index;
      logic [word_w-1:0]         wsel;    // word in line
      logic [offs_w-word_w-1:0]  boffs;   // byte in word, ignored
   } fetch_fields_t;

   // same 32 bits seen as a bus word or as cache fields
   typedef union packed {
      logic [addr_w-1:0]  raw;
      fetch_fields_t      f;
   } fetch_addr_u;

endpackage

// ==== dv/ncpu32k_icache_mem_model.sv ====
/*
 * Wishbone classic memory for the icache testbench
 * data is the word address XOR a key, 0 to 3 random wait states per beat
 */

`timescale 1ns/1ps

module ncpu32k_icache_mem_model #(
   parameter logic [31:0] DATA_KEY = 32'h5a5a_0000,
   parameter logic [31:0] SEED     = 32'h67b8c86a
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cyc,
   input  logic        stb,
   input  logic [31:0] adr,
   output logic        ack,
   output logic [31:0] dat,
   output logic [31:0] beats      // beats served since reset
);

   logic [31:0] lfsr;
   logic [31:0] lfsr_1;
   logic [31:0] lfsr_2;
   logic [1:0]  pick;             // wait states for a new beat
   logic [1:0]  wait_left;
   logic        busy;             // beat accepted, ack still owed

   // galois form, right shifting
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
   endfunction

   assign lfsr_1 = lfsr_step(lfsr);
   assign lfsr_2 = lfsr_step(lfsr_1);
   assign pick   = {lfsr_1[0], lfsr[0]};   // one step per bit

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr      <= SEED;
         ack       <= 1'b0;
         dat       <= '0;
         busy      <= 1'b0;
         wait_left <= '0;
         beats     <= '0;
      end else begin
         ack <= 1'b0;                        // single-cycle ack
         if (cyc && stb && ack) beats <= beats + 1'b1;

         if (cyc && stb && !ack && !busy) begin
            lfsr <= lfsr_2;
            if (pick == 2'd0) begin
               ack <= 1'b1;
               dat <= adr ^ DATA_KEY;
            end else begin
               busy      <= 1'b1;
               wait_left <= pick - 1'b1;
            end
         end else if (busy) begin
            if (wait_left == 2'd0) begin
               ack  <= 1'b1;
               dat  <= adr ^ DATA_KEY;      // adr held by the master
               busy <= 1'b0;
            end else begin
               wait_left <= wait_left - 1'b1;
            end
         end
      end
   end

endmodule

// ==== dv/ncpu32k_icache_tb.sv ====
/*
 * icache testbench
 * reset sweep, cold miss, hits, conflict eviction, flush and random fetches
 * against a wait-state memory, checked by concurrent assertions
 */

`timescale 1ns/1ps

module ncpu32k_icache_tb;

   localparam logic [31:0] data_key  = 32'h5a5a_0000;
   localparam logic [31:0] seed      = 32'h67b8c86a;
   localparam int          n_random  = 40;
   localparam int          n_req     = 1 + 4 + 6 + 2 + n_random;
   localparam int          wd_cycles = n_req * (64 + 4 * 8) + 200;

   logic        clk;
   logic        rst_n;
   logic        flush;
   logic        cpu_cyc;
   logic        cpu_stb;
   logic [31:0] cpu_adr;
   logic        cpu_ack;
   logic [31:0] cpu_dat;
   logic        mem_cyc;
   logic        mem_stb;
   logic [31:0] mem_adr;
   logic        mem_ack;
   logic [31:0] mem_dat;

   logic [31:0] beats;            // from the memory model
   logic [31:0] beats_at_req;     // beat count when the request went up
   logic [31:0] lfsr_state;
   logic [6:0]  quiet_cnt;        // sweep cycles left
   logic [31:0] mem_adr_q;
   logic        expect_hit;
   logic        expect_miss;

   ncpu32k_icache_pkg::fetch_addr_u req_view;
   logic [31:0] exp_dat;
   logic [31:0] beat_idx;
   logic [31:0] exp_mem_adr;
   logic [31:0] exp_beats;
   logic [31:0] ack_cyc;

   ncpu32k_icache ncpu32k_icache_inst (
      .clk, .rst_n, .flush,
      .cpu_cyc, .cpu_stb, .cpu_adr, .cpu_ack, .cpu_dat,
      .mem_cyc, .mem_stb, .mem_adr, .mem_ack, .mem_dat
   );

   ncpu32k_icache_mem_model #(.DATA_KEY(data_key), .SEED(seed)) u_mem (
      .clk, .rst_n,
      .cyc (mem_cyc), .stb (mem_stb), .adr (mem_adr),
      .ack (mem_ack), .dat (mem_dat), .beats
   );

   // #################### expected values
   assign req_view.raw = cpu_adr;
   assign exp_dat      = {req_view.f.tag, req_view.f.index, req_view.f.wsel, 2'b00} ^ data_key;
   assign beat_idx     = beats - beats_at_req;           // beats of this request
   assign exp_mem_adr  = {req_view.f.tag, req_view.f.index, 4'b0000} + (beat_idx << 2);
   assign exp_beats    = expect_miss ? 32'd4 : 32'd0;    // one full line or nothing
   assign ack_cyc      = {30'd0, cpu_ack, mem_cyc};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) quiet_cnt <= 7'd64;
      else if (flush) quiet_cnt <= 7'd64;               // sweep restarts
      else if (quiet_cnt != 7'd0) quiet_cnt <= quiet_cnt - 1'b1;
   end

   always_ff @(posedge clk) mem_adr_q <= mem_adr;

   // galois form shifting right
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i]       = lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
      $display("FAIL: see errors above");
      $fatal(1, "first error, run stopped");
   endtask

   // request held until the ack is seen and dropped for one cycle after
   task automatic fetch(input logic [31:0] adr, input bit want_hit, input bit want_miss,
                        input bit with_flush);
      @(negedge clk);
      expect_hit   = want_hit;
      expect_miss  = want_miss;
      beats_at_req = beats;
      flush        = with_flush;   // flush and request in the same cycle
      cpu_cyc      = 1'b1;
      cpu_stb      = 1'b1;
      cpu_adr      = adr;
      @(negedge clk);
      flush = 1'b0;
      while (!cpu_ack) @(negedge clk);
      @(negedge clk);
      cpu_cyc = 1'b0;
      cpu_stb = 1'b0;
   endtask

   // #################### checks
   a_sweep_quiet: assert property (@(posedge clk) quiet_cnt != 0 |-> !cpu_ack && !mem_cyc)
      else report_mismatch("sweep_quiet", 32'd0, $sampled(ack_cyc));

   a_ack_data: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_ack |-> cpu_dat == exp_dat)
      else report_mismatch("ack_data", $sampled(exp_dat), $sampled(cpu_dat));

   a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      expect_hit && $rose(cpu_stb) |=> cpu_ack)
      else report_mismatch("hit_latency", 32'd1, {31'd0, $sampled(cpu_ack)});

   a_hit_no_refill: assert property (@(posedge clk) disable iff (!rst_n)
      expect_hit |-> !mem_cyc)
      else report_mismatch("hit_no_refill", 32'd0, {31'd0, $sampled(mem_cyc)});

   a_beat_count: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_ack && (expect_hit || expect_miss) |-> beat_idx == exp_beats)
      else report_mismatch("beat_count", $sampled(exp_beats), $sampled(beat_idx));

   a_beat_adr: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && mem_ack |-> mem_adr == exp_mem_adr)
      else report_mismatch("beat_adr", $sampled(exp_mem_adr), $sampled(mem_adr));

   a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && !mem_ack |=> mem_stb)
      else report_mismatch("stb_hold", 32'd1, {31'd0, $sampled(mem_stb)});

   a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && !mem_ack |=> mem_adr == mem_adr_q)
      else report_mismatch("adr_stable", $sampled(mem_adr_q), $sampled(mem_adr));

   // #################### clock and reset
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
   end

   initial begin : watchdog
      repeat (wd_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the DUT never acked", wd_cycles);
      $display("FAIL: see errors above");
      $fatal(1, "simulation hung");
   end

   // #################### stimulus
   initial begin : stimulus
      logic [31:0] r;
      ncpu32k_icache_pkg::fetch_addr_u a;

      flush        = 1'b0;
      cpu_cyc      = 1'b0;
      cpu_stb      = 1'b0;
      cpu_adr      = '0;
      expect_hit   = 1'b0;
      expect_miss  = 1'b0;
      beats_at_req = '0;
      lfsr_state   = seed;

      fetch(32'h0000_1000, 1'b0, 1'b1, 1'b0);   // raised during reset as a cold miss
      fetch(32'h0000_1004, 1'b1, 1'b0, 1'b0);   // rest of the line hits
      fetch(32'h0000_1008, 1'b1, 1'b0, 1'b0);
      fetch(32'h0000_100c, 1'b1, 1'b0, 1'b0);
      fetch(32'h0000_1000, 1'b1, 1'b0, 1'b0);

      // index 4 shared by tags 0x0 and 0x108
      for (int i = 0; i < 3; i++) begin
         fetch(32'h0000_0044, 1'b0, 1'b1, 1'b0);
         fetch(32'h0004_2048, 1'b0, 1'b1, 1'b0);
      end

      fetch(32'h0000_1008, 1'b1, 1'b0, 1'b0);   // still resident
      fetch(32'h0000_1008, 1'b0, 1'b1, 1'b1);   // gone after flush

      // small tag and index space mixing hits and misses
      for (int i = 0; i < n_random; i++) begin
         take_bits(7, r);
         a.raw     = '0;
         a.f.tag   = 22'h100 + 22'(r[1:0]);
         a.f.index = 6'(r[4:2]);
         a.f.wsel  = r[6:5];
         fetch(a.raw, 1'b0, 1'b0, 1'b0);
      end

      repeat (4) @(negedge clk);
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== hdl/ncpu32k_cell_sdpram_sclk.sv ====
/*
 * simple dual-port synchronous RAM, single clock
 * registered read, optional write-to-read bypass
 */

`timescale 1ns/1ps

module ncpu32k_cell_sdpram_sclk #(
   parameter int AW            = 8,
   parameter int DW            = 32,
   parameter bit CLEAR_ON_INIT = 0,   // sim only
   parameter bit ENABLE_BYPASS = 1
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [AW-1:0] raddr,
   input  logic          re,
   input  logic [AW-1:0] waddr,
   input  logic          we,
   input  logic [DW-1:0] din,
   output logic [DW-1:0] dout
);

   localparam int depth = 1 << AW;

   logic [DW-1:0]    mem [depth];
   logic [DW-1:0]    dout_r;         // array read data
   logic [depth-1:0] wr_seen;        // entries written since reset

   if (CLEAR_ON_INIT) begin : g_clear
      initial begin
         for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
         end
      end
   end

   // array write and registered read
   always @(posedge clk) begin
      if (we) mem[waddr] <= din;
      if (re) dout_r <= mem[raddr];  // old data on a same-address write
   end

   if (ENABLE_BYPASS) begin : g_bypass
      logic          bypass;   // last read collided with a write
      logic [DW-1:0] din_r;

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) bypass <= 1'b0;
         else if (re) bypass <= we && (waddr == raddr);   // held till next read
      end

      always_ff @(posedge clk) begin
         if (re) din_r <= din;
      end

      assign dout = bypass ? din_r : dout_r;
   end else begin : g_no_bypass
      assign dout = dout_r;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) wr_seen <= '0;
      else if (we) wr_seen[waddr] <= 1'b1;
   end

   // a read of an initialised entry never comes back unknown
   a_read_known: assert property (@(posedge clk) disable iff (!rst_n)
      re && wr_seen[raddr] |=> !$isunknown(dout));

endmodule

// ==== icache/ncpu32k_icache.sv ====
/*
 * ncpu32k instruction cache
 * direct mapped, 64 lines of 4 words, read only
 * controller plus tag RAM and data RAM
 */

`timescale 1ns/1ps

module ncpu32k_icache (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  flush,     // one-cycle pulse
   // fetch port
   input  logic                                  cpu_cyc,
   input  logic                                  cpu_stb,
   input  logic [ncpu32k_icache_pkg::addr_w-1:0] cpu_adr,
   output logic                                  cpu_ack,
   output logic [ncpu32k_icache_pkg::data_w-1:0] cpu_dat,
   // refill port
   output logic                                  mem_cyc,
   output logic                                  mem_stb,
   output logic [ncpu32k_icache_pkg::addr_w-1:0] mem_adr,
   input  logic                                  mem_ack,
   input  logic [ncpu32k_icache_pkg::data_w-1:0] mem_dat
);

   logic [ncpu32k_icache_pkg::index_w-1:0]     tag_raddr;
   logic [ncpu32k_icache_pkg::index_w-1:0]     tag_waddr;
   logic                                       tag_re;
   logic                                       tag_we;
   logic [ncpu32k_icache_pkg::tag_ram_dw-1:0]  tag_din;
   logic [ncpu32k_icache_pkg::tag_ram_dw-1:0]  tag_dout;   // {valid, tag}

   logic [ncpu32k_icache_pkg::data_ram_aw-1:0] data_raddr;
   logic [ncpu32k_icache_pkg::data_ram_aw-1:0] data_waddr;
   logic                                       data_re;
   logic                                       data_we;
   logic [ncpu32k_icache_pkg::data_w-1:0]      data_din;
   logic [ncpu32k_icache_pkg::data_w-1:0]      data_dout;

   ncpu32k_icache_ctrl u_ctrl (
      .clk, .rst_n, .flush,
      .cpu_cyc, .cpu_stb, .cpu_adr, .cpu_ack, .cpu_dat,
      .mem_cyc, .mem_stb, .mem_adr, .mem_ack, .mem_dat,
      .tag_raddr, .tag_re, .tag_waddr, .tag_we, .tag_din, .tag_dout,
      .data_raddr, .data_re, .data_waddr, .data_we, .data_din, .data_dout
   );

   // one entry per line, cleared by the sweep
   ncpu32k_cell_sdpram_sclk #(
      .AW            (ncpu32k_icache_pkg::index_w),
      .DW            (ncpu32k_icache_pkg::tag_ram_dw),
      .CLEAR_ON_INIT (1'b0),
      .ENABLE_BYPASS (1'b1)   // tag write and relook share a cycle
   ) tag_ram (
      .clk, .rst_n,
      .raddr (tag_raddr), .re (tag_re),
      .waddr (tag_waddr), .we (tag_we),
      .din   (tag_din),   .dout (tag_dout)
   );

   // line words, addressed {index, word}
   ncpu32k_cell_sdpram_sclk #(
      .AW            (ncpu32k_icache_pkg::data_ram_aw),
      .DW            (ncpu32k_icache_pkg::data_w),
      .CLEAR_ON_INIT (1'b0),
      .ENABLE_BYPASS (1'b1)
   ) data_ram (
      .clk, .rst_n,
      .raddr (data_raddr), .re (data_re),
      .waddr (data_waddr), .we (data_we),
      .din   (data_din),   .dout (data_dout)
   );

endmodule

// ==== icache/ncpu32k_icache_ctrl.sv ====
/*
 * icache controller
 * lookup and tag compare, line refill over the Wishbone master,
 * tag invalidate sweep after reset and on flush
 */

`timescale 1ns/1ps

module ncpu32k_icache_ctrl (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   flush,
   // cpu side, Wishbone slave
   input  logic                                   cpu_cyc,
   input  logic                                   cpu_stb,
   input  logic [ncpu32k_icache_pkg::addr_w-1:0]  cpu_adr,
   output logic                                   cpu_ack,
   output logic [ncpu32k_icache_pkg::data_w-1:0]  cpu_dat,
   // memory side, Wishbone master
   output logic                                   mem_cyc,
   output logic                                   mem_stb,
   output logic [ncpu32k_icache_pkg::addr_w-1:0]  mem_adr,
   input  logic                                   mem_ack,
   input  logic [ncpu32k_icache_pkg::data_w-1:0]  mem_dat,
   // tag RAM
   output logic [ncpu32k_icache_pkg::index_w-1:0] tag_raddr,
   output logic                                   tag_re,
   output logic [ncpu32k_icache_pkg::index_w-1:0] tag_waddr,
   output logic                                   tag_we,
   output logic [ncpu32k_icache_pkg::tag_ram_dw-1:0] tag_din,
   input  logic [ncpu32k_icache_pkg::tag_ram_dw-1:0] tag_dout,
   // data RAM
   output logic [ncpu32k_icache_pkg::data_ram_aw-1:0] data_raddr,
   output logic                                   data_re,
   output logic [ncpu32k_icache_pkg::data_ram_aw-1:0] data_waddr,
   output logic                                   data_we,
   output logic [ncpu32k_icache_pkg::data_w-1:0]  data_din,
   input  logic [ncpu32k_icache_pkg::data_w-1:0]  data_dout
);

   localparam int tag_w   = ncpu32k_icache_pkg::tag_w;
   localparam int index_w = ncpu32k_icache_pkg::index_w;
   localparam int word_w  = ncpu32k_icache_pkg::word_w;
   localparam int byte_w  = ncpu32k_icache_pkg::offs_w - word_w;

   typedef enum logic [2:0] {
      S_SWEEP,    // invalidate all tags
      S_IDLE,     // wait for a fetch
      S_CMP,      // tag compare
      S_REFILL,   // 4 memory beats
      S_RELOOK    // write tag, look up again
   } state_t;

   state_t state, state_nxt;

   ncpu32k_icache_pkg::fetch_addr_u cur_adr;   // address on the cpu port
   ncpu32k_icache_pkg::fetch_addr_u req_adr;   // latched request
   ncpu32k_icache_pkg::fetch_addr_u lk_adr;    // address of the lookup

   logic [index_w-1:0] sweep_cnt;
   logic [word_w-1:0]  refill_cnt;   // word being fetched
   logic               beat_gap;     // stb low between beats
   logic               flush_pend;
   logic               flush_any;
   logic               tag_valid;
   logic               hit;
   logic               last_beat;

   assign cur_adr.raw = cpu_adr;
   assign lk_adr      = (state == S_IDLE) ? cur_adr : req_adr;   // relook uses latched
   assign flush_any   = flush | flush_pend;

   // #################### lookup
   assign tag_valid = tag_dout[tag_w];
   assign hit       = tag_valid && (tag_dout[tag_w-1:0] == req_adr.f.tag);

   assign tag_raddr  = lk_adr.f.index;
   assign data_raddr = {lk_adr.f.index, lk_adr.f.wsel};
   assign cpu_dat    = data_dout;   // qualified by cpu_ack

   // #################### refill
   assign mem_adr    = {req_adr.f.tag, req_adr.f.index, refill_cnt, {byte_w{1'b0}}};
   assign data_waddr = {req_adr.f.index, refill_cnt};
   assign data_din   = mem_dat;
   assign last_beat  = (refill_cnt == word_w'(ncpu32k_icache_pkg::line_words - 1));

   // next state and per-state strobes
   always_comb begin
      state_nxt = state;
      cpu_ack   = 1'b0;
      mem_cyc   = 1'b0;
      mem_stb   = 1'b0;
      tag_re    = 1'b0;
      tag_we    = 1'b0;
      tag_waddr = req_adr.f.index;
      tag_din   = {1'b1, req_adr.f.tag};   // valid entry
      data_re   = 1'b0;
      data_we   = 1'b0;

      case (state)
         S_SWEEP: begin
            tag_we    = 1'b1;
            tag_waddr = sweep_cnt;
            tag_din   = '0;   // valid clear
            if (sweep_cnt == index_w'(ncpu32k_icache_pkg::num_lines - 1))
               state_nxt = S_IDLE;
         end
         S_IDLE: begin
            if (flush_any) begin
               state_nxt = S_SWEEP;
            end else if (cpu_cyc && cpu_stb) begin
               tag_re    = 1'b1;   // both RAMs read together
               data_re   = 1'b1;
               state_nxt = S_CMP;
            end
         end
         S_CMP: begin
            if (flush_any) begin
               state_nxt = S_SWEEP;   // request stays pending
            end else if (hit) begin
               cpu_ack   = 1'b1;
               state_nxt = S_IDLE;
            end else begin
               state_nxt = S_REFILL;
            end
         end
         S_REFILL: begin
            mem_cyc = 1'b1;       // held over all beats
            mem_stb = !beat_gap;
            if (mem_stb && mem_ack) begin
               data_we = 1'b1;
               if (last_beat) state_nxt = S_RELOOK;
            end
         end
         S_RELOOK: begin
            tag_we    = 1'b1;   // same index read and written, bypass returns it
            tag_re    = 1'b1;
            data_re   = 1'b1;
            state_nxt = S_CMP;
         end
         default: state_nxt = S_SWEEP;
      endcase
   end

   // #################### registers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= S_SWEEP;   // sweep straight out of reset
         sweep_cnt  <= '0;
         refill_cnt <= '0;
         beat_gap   <= 1'b0;
         flush_pend <= 1'b0;
      end else begin
         state    <= state_nxt;
         beat_gap <= mem_stb && mem_ack;   // one idle cycle after each beat

         if (state == S_SWEEP) sweep_cnt <= sweep_cnt + 1'b1;   // wraps to 0 at end
         else sweep_cnt <= '0;

         if (state == S_CMP) refill_cnt <= '0;
         else if (mem_stb && mem_ack) refill_cnt <= refill_cnt + 1'b1;

         // flush seen outside idle is served once back in idle
         if (state != S_SWEEP && state_nxt == S_SWEEP) flush_pend <= 1'b0;
         else if (flush) flush_pend <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && tag_re) req_adr <= cur_adr;
   end

   // #################### checks
   a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_ack |=> !cpu_ack);

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb |-> mem_cyc);

   a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_stb && !mem_ack |=> mem_stb && $stable(mem_adr));

endmodule

// ==== vlog.f ====
common/ncpu32k_icache_pkg.sv
hdl/ncpu32k_cell_sdpram_sclk.sv
icache/ncpu32k_icache_ctrl.sv
icache/ncpu32k_icache.sv
dv/ncpu32k_icache_mem_model.sv
dv/ncpu32k_icache_tb.sv
